// File: Bender.yml
package:
  name: microcode_front_end

sources:
  - microcodePkg.sv
  - opcodeDecoder.sv
  - microcodeRom.sv
  - microSequencer.sv
  - microcodeFrontEnd.sv
  - target: test
    files:
      - frontEndChecker.sv
      - frontEndTb.sv

// File: frontEndChecker.sv
`timescale 1ns/1ps

module frontEndChecker
(
	input  logic                  clk,
	input  logic                  rstN,
	input  logic                  mopStrobe,
	input  logic [7:0]            mop,
	input  logic [7:0]            dataByte,
	input  logic                  zeroFlag,
	input  microcodePkg::uOpT     uOp,
	input  microcodePkg::operandT operand,
	input  logic                  uopValid,
	input  logic                  pcInc,
	input  logic                  flagUpdate,
	input  logic                  mopDone,
	input  logic                  busy,
	output int                    checkErrors,
	output int                    timeouts,
	output int                    flowsChecked,
	output logic                  measuring
);

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	// Packed as {valid cycles, pcInc pulses, flagUpdate pulses}
	function automatic logic [23:0] expectFlow(input logic [7:0] opcode, input logic zero,
		input logic [7:0] cbData);
		logic [23:0] counts;
		counts = {8'd2, 8'd1, 8'd1};
		case (opcode)
			microcodePkg::opNop: counts = {8'd1, 8'd1, 8'd0};
			microcodePkg::opLdBn, microcodePkg::opLdCn, microcodePkg::opLdAn:
				counts = {8'd3, 8'd2, 8'd0};
			microcodePkg::opLdAB, microcodePkg::opLdAC, microcodePkg::opLdBA:
				counts = {8'd3, 8'd1, 8'd0};
			microcodePkg::opAddB, microcodePkg::opAddC, microcodePkg::opSubB,
			microcodePkg::opSubC:
				counts = {8'd3, 8'd1, 8'd1};
			microcodePkg::opIncC, microcodePkg::opDecA, microcodePkg::opDecC:
				counts = {8'd1, 8'd1, 8'd1};
			microcodePkg::opJr: counts = {8'd6, 8'd2, 8'd0};
			// Short path when the condition fails
			microcodePkg::opJrNz: counts = zero ? {8'd3, 8'd2, 8'd0} : {8'd6, 8'd2, 8'd0};
			microcodePkg::opJrZ:  counts = zero ? {8'd6, 8'd2, 8'd0} : {8'd3, 8'd2, 8'd0};
			microcodePkg::opMapCb:
			begin
				if (cbData == microcodePkg::cbBit7 || cbData == microcodePkg::cbRlB)
				begin
					counts = {8'd4, 8'd2, 8'd1};
				end
				else
				begin
					// One-byte fallback adds a PC step
					counts = {8'd4, 8'd3, 8'd1};
				end
			end
			default: counts = {8'd2, 8'd1, 8'd1};
		endcase
		return counts;
	endfunction

	// Final micro-op of each flow, packed as {micro-op, operand}
	function automatic logic [8:0] expectLastEntry(input logic [7:0] opcode, input logic zero,
		input logic [7:0] cbData);
		logic [8:0] entry;
		entry = {microcodePkg::nop, microcodePkg::none};
		case (opcode)
			// Immediate loads end by writing the fetched byte
			microcodePkg::opLdBn: entry = {microcodePkg::srm, microcodePkg::b};
			microcodePkg::opLdCn: entry = {microcodePkg::srm, microcodePkg::c};
			microcodePkg::opLdAn: entry = {microcodePkg::srm, microcodePkg::a};
			microcodePkg::opLdAB, microcodePkg::opLdAC, microcodePkg::opLdBA:
				entry = {microcodePkg::sma, microcodePkg::pc};
			microcodePkg::opAddB, microcodePkg::opAddC, microcodePkg::opSubB,
			microcodePkg::opSubC:
				entry = {microcodePkg::srx16, microcodePkg::a};
			microcodePkg::opIncC: entry = {microcodePkg::inc16, microcodePkg::c};
			microcodePkg::opDecA: entry = {microcodePkg::dec16, microcodePkg::a};
			microcodePkg::opDecC: entry = {microcodePkg::dec16, microcodePkg::c};
			microcodePkg::opJr:   entry = {microcodePkg::spc, microcodePkg::x16};
			// Not taken ends on the offset fetch
			microcodePkg::opJrNz:
			begin
				entry = zero ? {microcodePkg::srm, microcodePkg::x8}
					: {microcodePkg::spc, microcodePkg::x16};
			end
			microcodePkg::opJrZ:
			begin
				entry = zero ? {microcodePkg::spc, microcodePkg::x16}
					: {microcodePkg::srm, microcodePkg::x8};
			end
			microcodePkg::opMapCb:
			begin
				if (cbData == microcodePkg::cbBit7)
				begin
					entry = {microcodePkg::bitTest, microcodePkg::none};
				end
				else if (cbData == microcodePkg::cbRlB)
				begin
					entry = {microcodePkg::shl, microcodePkg::none};
				end
				else
				begin
					entry = {microcodePkg::z801bop, microcodePkg::a};
				end
			end
			default: entry = {microcodePkg::nop, microcodePkg::none};
		endcase
		return entry;
	endfunction

	task automatic reportMismatch(input string msg);
		checkErrors++;
		$display("CHECK FAILED at %0t: %s", $time, msg);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Flow measurement
	//////////////////////////////////////////////////////////////////////

	task automatic measureFlow(input logic [7:0] opcode, input logic zero,
		input logic [7:0] cbData);
		logic [23:0] expected;
		logic [8:0]  expectedEntry;
		logic [8:0]  lastEntry;
		int          nValid;
		int          nPc;
		int          nFu;
		int          cycles;
		logic        done;
		expected = expectFlow(opcode, zero, cbData);
		expectedEntry = expectLastEntry(opcode, zero, cbData);
		lastEntry = '0;
		nValid = 0;
		nPc = 0;
		nFu = 0;
		cycles = 0;
		done = 1'b0;
		while (!done && cycles < 64)
		begin
			@(negedge clk);
			cycles++;
			if (cycles == 1 && !uopValid)
			begin
				reportMismatch($sformatf("opcode %h: no uopValid one cycle after strobe", opcode));
			end
			if (uopValid)
			begin
				nValid++;
			end
			if (pcInc)
			begin
				nPc++;
			end
			if (flagUpdate)
			begin
				nFu++;
			end
			lastEntry = {uOp, operand};
			done = mopDone;
		end
		if (!done)
		begin
			timeouts++;
			$display("Timeout at %0t: mopDone never came for opcode %h", $time, opcode);
		end
		else
		begin
			if (nValid != expected[23:16])
			begin
				reportMismatch($sformatf("opcode %h: %0d valid cycles, expected %0d",
					opcode, nValid, expected[23:16]));
			end
			if (nPc != expected[15:8])
			begin
				reportMismatch($sformatf("opcode %h: %0d pcInc pulses, expected %0d",
					opcode, nPc, expected[15:8]));
			end
			if (nFu != expected[7:0])
			begin
				reportMismatch($sformatf("opcode %h: %0d flagUpdate pulses, expected %0d",
					opcode, nFu, expected[7:0]));
			end
			if (lastEntry != expectedEntry)
			begin
				reportMismatch($sformatf("opcode %h: last entry %h, expected %h",
					opcode, lastEntry, expectedEntry));
			end
		end
	endtask

	// Watch idle cycles, start a measurement on each accepted strobe
	initial
	begin
		checkErrors = 0;
		timeouts = 0;
		flowsChecked = 0;
		measuring = 1'b0;
		forever
		begin
			@(negedge clk);
			if (rstN)
			begin
				if (uopValid || pcInc || flagUpdate || mopDone || busy)
				begin
					reportMismatch("control output high while idle");
				end
				if (mopStrobe && !busy)
				begin
					measuring = 1'b1;
					flowsChecked++;
					measureFlow(mop, zeroFlag, dataByte);
					measuring = 1'b0;
				end
			end
		end
	end

endmodule

// File: frontEndTb.sv
`timescale 1ns/1ps

module frontEndTb;

	logic                  clk;
	logic                  rstN;
	logic                  mopStrobe;
	microcodePkg::mopT     mop;
	microcodePkg::mopT     dataByte;
	logic                  zeroFlag;
	microcodePkg::uOpT     uOp;
	microcodePkg::operandT operand;
	logic                  uopValid;
	logic                  pcInc;
	logic                  flagUpdate;
	logic                  mopDone;
	logic                  busy;
	int                    checkErrors;
	int                    checkerTimeouts;
	int                    flowsChecked;
	logic                  measuring;
	int                    waitTimeouts;
	int                    flowsSent;
	int                    flowErrors;
	int                    drainCycles;
	integer                seed;
	logic [31:0]           rnd;
	microcodePkg::mopT     otherCb;
	microcodePkg::mopT     keptOps [0:17];

	microcodeFrontEnd dut
	(
		.clk        (clk),
		.rstN       (rstN),
		.mopStrobe  (mopStrobe),
		.mop        (mop),
		.dataByte   (dataByte),
		.zeroFlag   (zeroFlag),
		.uOp        (uOp),
		.operand    (operand),
		.uopValid   (uopValid),
		.pcInc      (pcInc),
		.flagUpdate (flagUpdate),
		.mopDone    (mopDone),
		.busy       (busy)
	);

	frontEndChecker watcher
	(
		.clk          (clk),
		.rstN         (rstN),
		.mopStrobe    (mopStrobe),
		.mop          (mop),
		.dataByte     (dataByte),
		.zeroFlag     (zeroFlag),
		.uOp          (uOp),
		.operand      (operand),
		.uopValid     (uopValid),
		.pcInc        (pcInc),
		.flagUpdate   (flagUpdate),
		.mopDone      (mopDone),
		.busy         (busy),
		.checkErrors  (checkErrors),
		.timeouts     (checkerTimeouts),
		.flowsChecked (flowsChecked),
		.measuring    (measuring)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus tasks
	//////////////////////////////////////////////////////////////////////

	// One-cycle strobe; zeroFlag and dataByte stay put afterwards
	task automatic pulseStrobe(input microcodePkg::mopT opcode, input logic zero,
		input microcodePkg::mopT cbData);
		@(posedge clk);
		#1;
		mop = opcode;
		zeroFlag = zero;
		dataByte = cbData;
		mopStrobe = 1'b1;
		@(posedge clk);
		#1;
		mopStrobe = 1'b0;
	endtask

	task automatic waitIdle;
		int cycles;
		cycles = 0;
		while (busy && cycles < 64)
		begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (busy)
		begin
			waitTimeouts++;
			$display("Timeout at %0t: DUT stayed busy for 64 cycles", $time);
		end
	endtask

	task automatic runOp(input microcodePkg::mopT opcode, input logic zero,
		input microcodePkg::mopT cbData);
		flowsSent++;
		pulseStrobe(opcode, zero, cbData);
		waitIdle();
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		rstN = 1'b0;
		mopStrobe = 1'b0;
		mop = 8'h00;
		dataByte = 8'h00;
		zeroFlag = 1'b0;
		waitTimeouts = 0;
		flowsSent = 0;
		flowErrors = 0;
		drainCycles = 0;
		seed = 32'h927e;
		keptOps = '{microcodePkg::opNop, microcodePkg::opLdBn, microcodePkg::opLdCn,
			microcodePkg::opLdAn, microcodePkg::opLdAB, microcodePkg::opLdAC,
			microcodePkg::opLdBA, microcodePkg::opAddB, microcodePkg::opAddC,
			microcodePkg::opSubB, microcodePkg::opSubC, microcodePkg::opIncC,
			microcodePkg::opDecA, microcodePkg::opDecC, microcodePkg::opJr,
			microcodePkg::opJrNz, microcodePkg::opJrZ, microcodePkg::opMapCb};
		repeat (16) @(posedge clk);
		#1;
		rstN = 1'b1;

		// Quiet period, the watcher checks the idle outputs
		repeat (5) @(posedge clk);

		for (int i = 0; i < 18; i++)
		begin
			runOp(keptOps[i], 1'b0, microcodePkg::cbBit7);
		end

		// Conditional jumps, both flag values
		runOp(microcodePkg::opJrNz, 1'b1, 8'h00);
		runOp(microcodePkg::opJrNz, 1'b0, 8'h00);
		runOp(microcodePkg::opJrZ, 1'b1, 8'h00);
		runOp(microcodePkg::opJrZ, 1'b0, 8'h00);

		// CB prefix with known and unknown second byte
		rnd = $random(seed);
		otherCb = rnd[7:0];
		if (otherCb == microcodePkg::cbBit7 || otherCb == microcodePkg::cbRlB)
		begin
			otherCb = otherCb ^ 8'h01;
		end
		runOp(microcodePkg::opMapCb, 1'b0, microcodePkg::cbBit7);
		runOp(microcodePkg::opMapCb, 1'b1, microcodePkg::cbRlB);
		runOp(microcodePkg::opMapCb, 1'b0, otherCb);

		// Second strobe lands while JR is still running
		flowsSent++;
		pulseStrobe(microcodePkg::opJr, 1'b0, 8'h00);
		pulseStrobe(microcodePkg::opAddB, 1'b0, 8'h00);
		waitIdle();

		for (int i = 0; i < 200; i++)
		begin
			rnd = $random(seed);
			runOp(rnd[7:0], rnd[8], rnd[23:16]);
		end

		while (measuring && drainCycles < 64)
		begin
			@(posedge clk);
			#1;
			drainCycles++;
		end
		if (measuring)
		begin
			waitTimeouts++;
			$display("Timeout at %0t: watcher still waiting for the last flow", $time);
		end
		if (flowsChecked != flowsSent)
		begin
			flowErrors++;
			$display("CHECK FAILED at %0t: watcher saw %0d flows, expected %0d",
				$time, flowsChecked, flowsSent);
		end

		$display("Errors: %0d check, %0d flow count, %0d timeout", checkErrors, flowErrors,
			checkerTimeouts + waitTimeouts);
		if (checkErrors == 0 && flowErrors == 0 && checkerTimeouts == 0 && waitTimeouts == 0)
		begin
			$display(">>> PASS");
		end
		else
		begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// File: microSequencer.sv
`timescale 1ns/1ps

module microSequencer
(
	input  logic                  clk,
	input  logic                  rstN,
	input  logic                  mopStrobe,
	input  microcodePkg::mopT     mop,
	input  microcodePkg::mopT     dataByte,
	input  logic                  zeroFlag,
	input  microcodePkg::uAddrT   flowStart,
	input  microcodePkg::uAddrT   cbFlowStart,
	input  microcodePkg::uopT     uop,
	output microcodePkg::mopT     mopOut,
	output microcodePkg::mopT     cbByte,
	output microcodePkg::uAddrT   uAddr,
	output microcodePkg::uOpT     uOp,
	output microcodePkg::operandT operand,
	output logic                  uopValid,
	output logic                  pcInc,
	output logic                  flagUpdate,
	output logic                  mopDone,
	output logic                  busy
);

	microcodePkg::seqStateT state;
	microcodePkg::uAddrT    uAddrQ;
	microcodePkg::flowCtlT  flowCtl;
	logic                   running;
	logic                   endFlow;
	logic                   incType;
	logic                   fuType;

	// Lookups see the raw bytes, the address register decides when they count
	assign mopOut  = mop;
	assign cbByte  = dataByte;
	assign uAddr   = uAddrQ;

	// Split the current entry
	assign flowCtl = microcodePkg::flowCtlT'(uop[12:9]);
	assign uOp     = microcodePkg::uOpT'(uop[8:4]);
	assign operand = microcodePkg::operandT'(uop[3:0]);

	//////////////////////////////////////////////////////////////////////
	// Flow control decode
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		endFlow = 1'b0;
		incType = 1'b0;
		fuType  = 1'b0;
		case (flowCtl)
			microcodePkg::inc:         incType = 1'b1;
			microcodePkg::eof:         endFlow = 1'b1;
			microcodePkg::updateFlags: fuType  = 1'b1;
			// CB jump also steps past the prefix operand
			microcodePkg::jcb:         incType = 1'b1;
			microcodePkg::incEof:
			begin
				incType = 1'b1;
				endFlow = 1'b1;
			end
			microcodePkg::eofFu:
			begin
				endFlow = 1'b1;
				fuType  = 1'b1;
			end
			microcodePkg::incEofFu:
			begin
				incType = 1'b1;
				endFlow = 1'b1;
				fuType  = 1'b1;
			end
			microcodePkg::incEofZ:
			begin
				incType = 1'b1;
				endFlow = zeroFlag;
			end
			microcodePkg::incEofNz:
			begin
				incType = 1'b1;
				endFlow = ~zeroFlag;
			end
			default:
			begin
				endFlow = 1'b0;
			end
		endcase
	end

	assign running    = (state == microcodePkg::run);
	assign uopValid   = running;
	assign busy       = running;
	assign pcInc      = running & incType;
	assign flagUpdate = running & fuType;
	assign mopDone    = running & endFlow;

	//////////////////////////////////////////////////////////////////////
	// State and micro-address
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			state  <= microcodePkg::idle;
			uAddrQ <= '0;
		end
		else if (!running)
		begin
			// Strobes while a flow runs are dropped
			if (mopStrobe)
			begin
				state  <= microcodePkg::run;
				uAddrQ <= flowStart;
			end
		end
		else if (endFlow)
		begin
			state <= microcodePkg::idle;
		end
		else if (flowCtl == microcodePkg::jcb)
		begin
			uAddrQ <= cbFlowStart;
		end
		else
		begin
			uAddrQ <= uAddrQ + 9'd1;
		end
	end

endmodule

// File: microcodeFrontEnd.sv
`timescale 1ns/1ps

module microcodeFrontEnd
(
	input  logic                  clk,
	input  logic                  rstN,
	input  logic                  mopStrobe,
	input  microcodePkg::mopT     mop,
	input  microcodePkg::mopT     dataByte,
	input  logic                  zeroFlag,
	output microcodePkg::uOpT     uOp,
	output microcodePkg::operandT operand,
	output logic                  uopValid,
	output logic                  pcInc,
	output logic                  flagUpdate,
	output logic                  mopDone,
	output logic                  busy
);

	microcodePkg::mopT   decMop;
	microcodePkg::mopT   cbByte;
	microcodePkg::uAddrT flowStart;
	microcodePkg::uAddrT cbFlowStart;
	microcodePkg::uAddrT uAddr;
	microcodePkg::uopT   uop;

	opcodeDecoder decoder
	(
		.mop         (decMop),
		.cbByte      (cbByte),
		.flowStart   (flowStart),
		.cbFlowStart (cbFlowStart)
	);

	microcodeRom rom
	(
		.uAddr (uAddr),
		.uop   (uop)
	);

	microSequencer sequencer
	(
		.clk         (clk),
		.rstN        (rstN),
		.mopStrobe   (mopStrobe),
		.mop         (mop),
		.dataByte    (dataByte),
		.zeroFlag    (zeroFlag),
		.flowStart   (flowStart),
		.cbFlowStart (cbFlowStart),
		.uop         (uop),
		.mopOut      (decMop),
		.cbByte      (cbByte),
		.uAddr       (uAddr),
		.uOp         (uOp),
		.operand     (operand),
		.uopValid    (uopValid),
		.pcInc       (pcInc),
		.flagUpdate  (flagUpdate),
		.mopDone     (mopDone),
		.busy        (busy)
	);

endmodule

// File: microcodePkg.sv
package microcodePkg;

	//////////////////////////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////////////////////////

	// Opcode or data byte
	typedef logic [7:0] mopT;

	// Micro-address into the ROM
	typedef logic [8:0] uAddrT;

	// Packed flow control, micro-operation and operand
	typedef logic [12:0] uopT;

	//////////////////////////////////////////////////////////////////////
	// Microcode fields
	//////////////////////////////////////////////////////////////////////

	// Flow control, how the sequencer moves after an entry
	typedef enum logic [3:0]
	{
		op,
		inc,
		eof,
		incEof,
		eofFu,
		incEofFu,
		incEofZ,
		incEofNz,
		updateFlags,
		jcb
	} flowCtlT;

	typedef enum logic [4:0]
	{
		nop, sma, srm, sx8r, srx8, sx16r, srx16, spc,
		addx16, subx16, inc16, dec16, bitTest, shl, z801bop
	} uOpT;

	typedef enum logic [3:0]
	{
		a, b, c, d, e, h, l, pc, x8, x16, none
	} operandT;

	typedef enum logic [1:0]
	{
		idle,
		run
	} seqStateT;

	//////////////////////////////////////////////////////////////////////
	// Opcodes
	//////////////////////////////////////////////////////////////////////

	localparam mopT opNop   = 8'h00;
	localparam mopT opLdBn  = 8'h06;
	localparam mopT opLdCn  = 8'h0E;
	localparam mopT opLdAn  = 8'h3E;
	localparam mopT opLdAB  = 8'h78;
	localparam mopT opLdAC  = 8'h79;
	localparam mopT opLdBA  = 8'h47;
	localparam mopT opAddB  = 8'h80;
	localparam mopT opAddC  = 8'h81;
	localparam mopT opSubB  = 8'h90;
	localparam mopT opSubC  = 8'h91;
	localparam mopT opIncC  = 8'h0C;
	localparam mopT opDecA  = 8'h3D;
	localparam mopT opDecC  = 8'h0D;
	localparam mopT opJr    = 8'h18;
	localparam mopT opJrNz  = 8'h20;
	localparam mopT opJrZ   = 8'h28;
	localparam mopT opMapCb = 8'hCB;

	// Second byte after the CB prefix
	localparam mopT cbBit7  = 8'h7C;
	localparam mopT cbRlB   = 8'h11;

	//////////////////////////////////////////////////////////////////////
	// Flow start addresses
	//////////////////////////////////////////////////////////////////////

	localparam uAddrT flowCb1Byte = 9'd0;
	localparam uAddrT flowNop     = 9'd1;
	localparam uAddrT flowLdBn    = 9'd2;
	localparam uAddrT flowLdCn    = 9'd5;
	localparam uAddrT flowLdAn    = 9'd8;
	localparam uAddrT flowLdAB    = 9'd11;
	localparam uAddrT flowLdAC    = 9'd14;
	localparam uAddrT flowLdBA    = 9'd17;
	localparam uAddrT flowAddB    = 9'd20;
	localparam uAddrT flowAddC    = 9'd23;
	localparam uAddrT flowSubB    = 9'd26;
	localparam uAddrT flowSubC    = 9'd29;
	localparam uAddrT flowIncC    = 9'd32;
	localparam uAddrT flowDecA    = 9'd33;
	localparam uAddrT flowDecC    = 9'd34;
	localparam uAddrT flowJr      = 9'd35;
	localparam uAddrT flowJrNz    = 9'd41;
	localparam uAddrT flowJrZ     = 9'd47;
	localparam uAddrT flowMapCb   = 9'd53;
	localparam uAddrT flowCbBit7  = 9'd56;
	localparam uAddrT flowCbRlB   = 9'd57;
	localparam uAddrT flowDefault = 9'd58;

endpackage

// File: microcodeRom.sv
`timescale 1ns/1ps

module microcodeRom
(
	input  microcodePkg::uAddrT uAddr,
	output microcodePkg::uopT   uop
);

	// Entry layout is {flow control, micro-op, operand}
	always_comb
	begin
		case (uAddr)
			// Generic one-byte op, also the CB fallback
			9'd0:  uop = {microcodePkg::incEofFu, microcodePkg::z801bop, microcodePkg::a};
			// NOP
			9'd1:  uop = {microcodePkg::incEof, microcodePkg::nop, microcodePkg::none};
			// LD B,n
			9'd2:  uop = {microcodePkg::inc, microcodePkg::sma, microcodePkg::pc};
			9'd3:  uop = {microcodePkg::inc, microcodePkg::nop, microcodePkg::none};
			9'd4:  uop = {microcodePkg::eof, microcodePkg::srm, microcodePkg::b};
			// LD C,n
			9'd5:  uop = {microcodePkg::inc, microcodePkg::sma, microcodePkg::pc};
			9'd6:  uop = {microcodePkg::inc, microcodePkg::nop, microcodePkg::none};
			9'd7:  uop = {microcodePkg::eof, microcodePkg::srm, microcodePkg::c};
			// LD A,n
			9'd8:  uop = {microcodePkg::inc, microcodePkg::sma, microcodePkg::pc};
			9'd9:  uop = {microcodePkg::inc, microcodePkg::nop, microcodePkg::none};
			9'd10: uop = {microcodePkg::eof, microcodePkg::srm, microcodePkg::a};
			// LD A,B
			9'd11: uop = {microcodePkg::op, microcodePkg::sx8r, microcodePkg::b};
			9'd12: uop = {microcodePkg::op, microcodePkg::srx8, microcodePkg::a};
			9'd13: uop = {microcodePkg::incEof, microcodePkg::sma, microcodePkg::pc};
			// LD A,C
			9'd14: uop = {microcodePkg::op, microcodePkg::sx8r, microcodePkg::c};
			9'd15: uop = {microcodePkg::op, microcodePkg::srx8, microcodePkg::a};
			9'd16: uop = {microcodePkg::incEof, microcodePkg::sma, microcodePkg::pc};
			// LD B,A
			9'd17: uop = {microcodePkg::op, microcodePkg::sx8r, microcodePkg::a};
			9'd18: uop = {microcodePkg::op, microcodePkg::srx8, microcodePkg::b};
			9'd19: uop = {microcodePkg::incEof, microcodePkg::sma, microcodePkg::pc};

			//////////////////////////////////////////////////////////////////////
			// Arithmetic through x16
			//////////////////////////////////////////////////////////////////////

			// ADD A,B
			9'd20: uop = {microcodePkg::op, microcodePkg::sx16r, microcodePkg::a};
			9'd21: uop = {microcodePkg::updateFlags, microcodePkg::addx16, microcodePkg::b};
			9'd22: uop = {microcodePkg::incEof, microcodePkg::srx16, microcodePkg::a};
			// ADD A,C
			9'd23: uop = {microcodePkg::op, microcodePkg::sx16r, microcodePkg::a};
			9'd24: uop = {microcodePkg::updateFlags, microcodePkg::addx16, microcodePkg::c};
			9'd25: uop = {microcodePkg::incEof, microcodePkg::srx16, microcodePkg::a};
			// SUB B
			9'd26: uop = {microcodePkg::op, microcodePkg::sx16r, microcodePkg::a};
			9'd27: uop = {microcodePkg::updateFlags, microcodePkg::subx16, microcodePkg::b};
			9'd28: uop = {microcodePkg::incEof, microcodePkg::srx16, microcodePkg::a};
			// SUB C
			9'd29: uop = {microcodePkg::op, microcodePkg::sx16r, microcodePkg::a};
			9'd30: uop = {microcodePkg::updateFlags, microcodePkg::subx16, microcodePkg::c};
			9'd31: uop = {microcodePkg::incEof, microcodePkg::srx16, microcodePkg::a};
			// INC C, DEC A, DEC C
			9'd32: uop = {microcodePkg::incEofFu, microcodePkg::inc16, microcodePkg::c};
			9'd33: uop = {microcodePkg::incEofFu, microcodePkg::dec16, microcodePkg::a};
			9'd34: uop = {microcodePkg::incEofFu, microcodePkg::dec16, microcodePkg::c};

			//////////////////////////////////////////////////////////////////////
			// Relative jumps
			//////////////////////////////////////////////////////////////////////

			// JR n
			9'd35: uop = {microcodePkg::inc, microcodePkg::sma, microcodePkg::pc};
			9'd36: uop = {microcodePkg::op, microcodePkg::nop, microcodePkg::none};
			9'd37: uop = {microcodePkg::inc, microcodePkg::srm, microcodePkg::x8};
			9'd38: uop = {microcodePkg::op, microcodePkg::sx16r, microcodePkg::pc};
			9'd39: uop = {microcodePkg::op, microcodePkg::addx16, microcodePkg::x8};
			9'd40: uop = {microcodePkg::eof, microcodePkg::spc, microcodePkg::x16};
			// JR NZ,n leaves early when zero is set
			9'd41: uop = {microcodePkg::inc, microcodePkg::sma, microcodePkg::pc};
			9'd42: uop = {microcodePkg::op, microcodePkg::nop, microcodePkg::none};
			9'd43: uop = {microcodePkg::incEofZ, microcodePkg::srm, microcodePkg::x8};
			9'd44: uop = {microcodePkg::op, microcodePkg::sx16r, microcodePkg::pc};
			9'd45: uop = {microcodePkg::op, microcodePkg::addx16, microcodePkg::x8};
			9'd46: uop = {microcodePkg::eof, microcodePkg::spc, microcodePkg::x16};
			// JR Z,n leaves early when zero is clear
			9'd47: uop = {microcodePkg::inc, microcodePkg::sma, microcodePkg::pc};
			9'd48: uop = {microcodePkg::op, microcodePkg::nop, microcodePkg::none};
			9'd49: uop = {microcodePkg::incEofNz, microcodePkg::srm, microcodePkg::x8};
			9'd50: uop = {microcodePkg::op, microcodePkg::sx16r, microcodePkg::pc};
			9'd51: uop = {microcodePkg::op, microcodePkg::addx16, microcodePkg::x8};
			9'd52: uop = {microcodePkg::eof, microcodePkg::spc, microcodePkg::x16};

			//////////////////////////////////////////////////////////////////////
			// CB prefix
			//////////////////////////////////////////////////////////////////////

			9'd53: uop = {microcodePkg::inc, microcodePkg::sma, microcodePkg::pc};
			9'd54: uop = {microcodePkg::op, microcodePkg::nop, microcodePkg::none};
			9'd55: uop = {microcodePkg::jcb, microcodePkg::nop, microcodePkg::none};
			// BIT 7
			9'd56: uop = {microcodePkg::eofFu, microcodePkg::bitTest, microcodePkg::none};
			// RL
			9'd57: uop = {microcodePkg::eofFu, microcodePkg::shl, microcodePkg::none};
			// Default flow for opcodes outside the table
			9'd58: uop = {microcodePkg::updateFlags, microcodePkg::z801bop, microcodePkg::a};
			9'd59: uop = {microcodePkg::incEof, microcodePkg::nop, microcodePkg::none};
			default:
			begin
				uop = {microcodePkg::op, microcodePkg::nop, microcodePkg::none};
			end
		endcase
	end

endmodule

// File: opcodeDecoder.sv
`timescale 1ns/1ps

module opcodeDecoder
(
	input  microcodePkg::mopT   mop,
	input  microcodePkg::mopT   cbByte,
	output microcodePkg::uAddrT flowStart,
	output microcodePkg::uAddrT cbFlowStart
);

	//////////////////////////////////////////////////////////////////////
	// Main opcode table
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		case (mop)
			microcodePkg::opNop:   flowStart = microcodePkg::flowNop;
			// Immediate loads
			microcodePkg::opLdBn:  flowStart = microcodePkg::flowLdBn;
			microcodePkg::opLdCn:  flowStart = microcodePkg::flowLdCn;
			microcodePkg::opLdAn:  flowStart = microcodePkg::flowLdAn;
			// Register moves
			microcodePkg::opLdAB:  flowStart = microcodePkg::flowLdAB;
			microcodePkg::opLdAC:  flowStart = microcodePkg::flowLdAC;
			microcodePkg::opLdBA:  flowStart = microcodePkg::flowLdBA;
			// 8-bit arithmetic
			microcodePkg::opAddB:  flowStart = microcodePkg::flowAddB;
			microcodePkg::opAddC:  flowStart = microcodePkg::flowAddC;
			microcodePkg::opSubB:  flowStart = microcodePkg::flowSubB;
			microcodePkg::opSubC:  flowStart = microcodePkg::flowSubC;
			microcodePkg::opIncC:  flowStart = microcodePkg::flowIncC;
			microcodePkg::opDecA:  flowStart = microcodePkg::flowDecA;
			microcodePkg::opDecC:  flowStart = microcodePkg::flowDecC;
			// Relative jumps
			microcodePkg::opJr:    flowStart = microcodePkg::flowJr;
			microcodePkg::opJrNz:  flowStart = microcodePkg::flowJrNz;
			microcodePkg::opJrZ:   flowStart = microcodePkg::flowJrZ;
			microcodePkg::opMapCb: flowStart = microcodePkg::flowMapCb;
			default:
			begin
				flowStart = microcodePkg::flowDefault;
			end
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// CB prefix table
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		case (cbByte)
			microcodePkg::cbBit7: cbFlowStart = microcodePkg::flowCbBit7;
			microcodePkg::cbRlB:  cbFlowStart = microcodePkg::flowCbRlB;
			// Unknown CB ops fall back to the one-byte flow
			default:
			begin
				cbFlowStart = microcodePkg::flowCb1Byte;
			end
		endcase
	end

endmodule

// File: verilog.f
microcodePkg.sv
opcodeDecoder.sv
microcodeRom.sv
microSequencer.sv
microcodeFrontEnd.sv
frontEndChecker.sv
frontEndTb.sv
